// File: hdl/gs_aux_select.sv
`timescale 1ns/1ps

module gs_aux_select (
	input  logic [7:0]  bank,
	input  logic [15:0] addr,
	input  logic        bus_write,
	input  logic        store80,
	input  logic        ramrd,
	input  logic        ramwrt,
	input  logic        altzp,
	input  logic        page2,
	input  logic        hires_mode,
	output logic        aux
);

	logic main_bank;
	logic rw_aux;

	assign main_bank = (bank == 8'h00) || (bank == 8'he0);
	assign rw_aux    = bus_write ? ramwrt : ramrd;

	always_comb begin
		if (!main_bank)
			aux = 1'b0;
		else if (addr[15:9] == 7'd0 || addr[15:14] == 2'b11) // zero page, stack, C0-FF
			aux = altzp;
		else if (addr[15:10] == 6'b000001) // text page 1
			aux = store80 ? page2 : rw_aux;
		else if (addr[15:13] == 3'b001) // hires page 1
			aux = (store80 && hires_mode) ? page2 : rw_aux;
		else
			aux = rw_aux;
	end

endmodule

// File: hdl/gs_glue.sv
`timescale 1ns/1ps

module gs_glue (
	input  logic        clk_sys,
	input  logic        cpu_vda,
	input  logic        bus_valid,
	input  logic        bus_write,
	input  logic [7:0]  cpu_bank,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	input  logic [7:0]  din,
	input  logic        vblank,
	output logic [7:0]  bank,
	output logic [15:0] addr,
	output logic [7:0]  cpu_din,
	output logic        io,
	output logic        aux,
	output logic [7:0]  shadow,
	output logic [7:0]  newvideo,
	output logic [7:0]  textcolor,
	output logic [3:0]  bordercolor,
	output logic [7:0]  sltromsel,
	output logic        cxrom,
	output logic        rdrom,
	output logic        lcram2,
	output logic        lc_we,
	output logic        page2,
	output logic        textg,
	output logic        mixg,
	output logic        hires_mode
);

	gs_pkg::bus_op_e io_op;
	logic       rombank;
	logic       store80;
	logic       ramrd;
	logic       ramwrt;
	logic       altzp;
	logic       state_load;
	logic [7:0] state_wdata;
	logic [7:0] sw_rdata;
	logic       sw_hit;
	logic [7:0] reg_rdata;
	logic       reg_hit;

	gs_lang_card gs_lang_card_i (
		.clk_sys     (clk_sys),
		.cpu_vda     (cpu_vda),
		.cpu_bank    (cpu_bank),
		.cpu_addr    (cpu_addr),
		.io_op       (io_op),
		.bank        (bank),
		.addr        (addr),
		.rdrom       (rdrom),
		.lcram2      (lcram2),
		.lc_we       (lc_we),
		.rombank     (rombank),
		.state_load  (state_load),
		.state_wdata (state_wdata)
	);

	gs_io_decode gs_io_decode_i (
		.bank      (bank),
		.addr      (addr),
		.bus_valid (bus_valid),
		.bus_write (bus_write),
		.shadow_io (shadow[6]),
		.sltromsel (sltromsel),
		.io        (io),
		.io_op     (io_op)
	);

	gs_softswitch gs_softswitch_i (
		.clk_sys     (clk_sys),
		.cpu_vda     (cpu_vda),
		.addr        (addr),
		.io_op       (io_op),
		.cpu_wdata   (cpu_wdata),
		.vblank      (vblank),
		.lcram2      (lcram2),
		.rdrom       (rdrom),
		.state_load  (state_load),
		.state_wdata (state_wdata),
		.store80     (store80),
		.ramrd       (ramrd),
		.ramwrt      (ramwrt),
		.intcxrom    (cxrom),
		.altzp       (altzp),
		.page2       (page2),
		.textg       (textg),
		.mixg        (mixg),
		.hires_mode  (hires_mode),
		.rdata       (sw_rdata),
		.hit         (sw_hit)
	);

	gs_megaii_regs gs_megaii_regs_i (
		.clk_sys     (clk_sys),
		.cpu_vda     (cpu_vda),
		.addr        (addr),
		.io_op       (io_op),
		.cpu_wdata   (cpu_wdata),
		.altzp       (altzp),
		.page2       (page2),
		.ramrd       (ramrd),
		.ramwrt      (ramwrt),
		.rdrom       (rdrom),
		.lcram2      (lcram2),
		.rombank     (rombank),
		.intcxrom    (cxrom),
		.shadow      (shadow),
		.newvideo    (newvideo),
		.textcolor   (textcolor),
		.sltromsel   (sltromsel),
		.bordercolor (bordercolor),
		.state_load  (state_load),
		.state_wdata (state_wdata),
		.rdata       (reg_rdata),
		.hit         (reg_hit)
	);

	gs_aux_select gs_aux_select_i (
		.bank       (bank),
		.addr       (addr),
		.bus_write  (bus_write),
		.store80    (store80),
		.ramrd      (ramrd),
		.ramwrt     (ramwrt),
		.altzp      (altzp),
		.page2      (page2),
		.hires_mode (hires_mode),
		.aux        (aux)
	);

	gs_read_mux gs_read_mux_i (
		.clk_sys   (clk_sys),
		.cpu_vda   (cpu_vda),
		.io_op     (io_op),
		.sw_rdata  (sw_rdata),
		.sw_hit    (sw_hit),
		.reg_rdata (reg_rdata),
		.reg_hit   (reg_hit),
		.din       (din),
		.cpu_din   (cpu_din)
	);

endmodule

// File: hdl/gs_io_decode.sv
`timescale 1ns/1ps
`include "gs_macros.svh"

module gs_io_decode (
	input  logic [7:0]      bank,
	input  logic [15:0]     addr,
	input  logic            bus_valid,
	input  logic            bus_write,
	input  logic            shadow_io,
	input  logic [7:0]      sltromsel,
	output logic            io,
	output gs_pkg::bus_op_e io_op
);

	logic in_bank;
	logic in_window;
	logic slot_io;
	logic ext_io;

	assign in_bank = gs_pkg::is_io_bank(bank);

	// shadow bit 6 widens the window to C000-DFFF
	assign in_window = shadow_io ? (addr[15:13] == 3'b110) : (addr[15:8] == `GS_IO_PAGE);

	// slot I/O area, handed out per slot by the slot ROM select register
	assign slot_io = (addr[15:8] == `GS_IO_PAGE) && (addr[7:0] >= `GS_EXT_IO_LO);
	assign ext_io  = slot_io && sltromsel[addr[6:4]];

	assign io = in_bank && in_window && !ext_io;

	always_comb begin
		if (!(bus_valid && io))
			io_op = gs_pkg::BUS_IDLE;
		else if (bus_write)
			io_op = gs_pkg::BUS_WRITE;
		else
			io_op = gs_pkg::BUS_READ;
	end

endmodule

// File: hdl/gs_lang_card.sv
`timescale 1ns/1ps
`include "gs_macros.svh"

module gs_lang_card (
	input  logic            clk_sys,
	input  logic            cpu_vda,
	input  logic [7:0]      cpu_bank,
	input  logic [15:0]     cpu_addr,
	input  gs_pkg::bus_op_e io_op,
	output logic [7:0]      bank,
	output logic [15:0]     addr,
	output logic            rdrom,
	output logic            lcram2,
	output logic            lc_we,
	output logic            rombank,
	input  logic            state_load,
	input  logic [7:0]      state_wdata
);

	gs_pkg::lc_mode_e lc_mode;
	logic lc_hit;
	logic rombank_hit;
	logic mode_rdrom;
	logic mode_bank2;
	logic mode_we;
	logic in_lc;

	// bank 2 RAM lives 4K lower, under the C000 page
	assign in_lc = gs_pkg::is_io_bank(cpu_bank) &&
		(cpu_addr >= `GS_LC_LO) && (cpu_addr <= `GS_LC_HI);

	assign bank = cpu_bank;
	assign addr = (in_lc && lcram2 && !rdrom) ? cpu_addr - `GS_LC_REMAP_OFS : cpu_addr;

	// reads and writes both switch the card
	assign lc_hit      = (io_op != gs_pkg::BUS_IDLE) && (addr[11:4] == 8'h08);
	assign rombank_hit = (io_op != gs_pkg::BUS_IDLE) && (addr[11:0] == `GS_REG_ROMBANK);
	assign lc_mode     = gs_pkg::lc_mode_e'({addr[3], addr[1], addr[0]});

	always_comb begin
		mode_bank2 = !lc_mode[2];
		mode_we    = lc_mode[0];
		case (lc_mode)
			gs_pkg::LC_RAM_B2_RO, gs_pkg::LC_RAM_B2_WE,
			gs_pkg::LC_RAM_B1_RO, gs_pkg::LC_RAM_B1_WE: mode_rdrom = 1'b0;
			default: mode_rdrom = 1'b1;
		endcase
	end

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			rdrom   <= 1'b1;
			lcram2  <= 1'b1;
			lc_we   <= 1'b0;
			rombank <= 1'b0;
		end else if (state_load) begin
			rdrom   <= !state_wdata[3]; // C068 holds the inverse
			lcram2  <= state_wdata[2];
			rombank <= state_wdata[1];
		end else begin
			if (lc_hit) begin
				rdrom  <= mode_rdrom;
				lcram2 <= mode_bank2;
				lc_we  <= mode_we;
			end
			if (rombank_hit)
				rombank <= !rombank;
		end
	end

	lc_we_rom_ro_a: assert property (@(posedge clk_sys) disable iff (cpu_vda)
		lc_hit && (lc_mode == gs_pkg::LC_ROM_B2_RO || lc_mode == gs_pkg::LC_ROM_B1_RO)
		|=> !lc_we);

endmodule

// File: hdl/gs_macros.svh
`ifndef GS_MACROS_SVH
`define GS_MACROS_SVH

// I/O page and the slot carve-out
`define GS_IO_PAGE        8'hc0
`define GS_EXT_IO_LO      8'h90     // C090..C0FF can go to slot cards

// language card window and the bank 2 remap distance
`define GS_LC_LO          16'hd000
`define GS_LC_HI          16'hdfff
`define GS_LC_REMAP_OFS   16'h1000

// soft switch status reads put the flag in bit 7
`define GS_STATUS_ON      8'h80

// system register offsets within the C0 page
`define GS_REG_TEXTCOLOR  12'h022
`define GS_REG_ROMBANK    12'h028
`define GS_REG_NEWVIDEO   12'h029
`define GS_REG_C02B       12'h02b
`define GS_REG_SLTROMSEL  12'h02d
`define GS_REG_BORDER     12'h034
`define GS_REG_SHADOW     12'h035
`define GS_REG_CYA        12'h036
`define GS_REG_STATE      12'h068

// reset values
`define GS_RST_SHADOW     8'h08
`define GS_RST_NEWVIDEO   8'h41
`define GS_RST_CYA        8'h80     // fast speed
`define GS_RST_C02B       8'h08

`endif

// File: hdl/gs_megaii_regs.sv
`timescale 1ns/1ps
`include "gs_macros.svh"

module gs_megaii_regs (
	input  logic            clk_sys,
	input  logic            cpu_vda,
	input  logic [15:0]     addr,
	input  gs_pkg::bus_op_e io_op,
	input  logic [7:0]      cpu_wdata,
	input  logic            altzp,
	input  logic            page2,
	input  logic            ramrd,
	input  logic            ramwrt,
	input  logic            rdrom,
	input  logic            lcram2,
	input  logic            rombank,
	input  logic            intcxrom,
	output logic [7:0]      shadow,
	output logic [7:0]      newvideo,
	output logic [7:0]      textcolor,
	output logic [7:0]      sltromsel,
	output logic [3:0]      bordercolor,
	output logic            state_load,
	output logic [7:0]      state_wdata,
	output logic [7:0]      rdata,
	output logic            hit
);

	logic [7:0] cya;
	logic [7:0] c02b;
	logic wr;

	assign wr = (io_op == gs_pkg::BUS_WRITE);

	// C068 is not stored here, the switches own its bits
	assign state_load  = wr && (addr[11:0] == `GS_REG_STATE);
	assign state_wdata = cpu_wdata;

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			shadow      <= `GS_RST_SHADOW;
			newvideo    <= `GS_RST_NEWVIDEO;
			cya         <= `GS_RST_CYA;
			c02b        <= `GS_RST_C02B;
			textcolor   <= 8'h00;
			sltromsel   <= 8'h00;
			bordercolor <= 4'h0;
		end else if (wr) begin
			case (addr[11:0])
				`GS_REG_TEXTCOLOR: textcolor   <= cpu_wdata;
				`GS_REG_NEWVIDEO:  newvideo    <= cpu_wdata;
				`GS_REG_C02B:      c02b        <= cpu_wdata;
				`GS_REG_SLTROMSEL: sltromsel   <= cpu_wdata;
				`GS_REG_BORDER:    bordercolor <= cpu_wdata[3:0]; // top nibble is the RTC
				`GS_REG_SHADOW:    shadow      <= cpu_wdata;
				`GS_REG_CYA:       cya         <= cpu_wdata;
				default: ;
			endcase
		end
	end

	always_comb begin
		hit   = (io_op == gs_pkg::BUS_READ);
		rdata = 8'h00;
		case (addr[11:0])
			`GS_REG_TEXTCOLOR: rdata = textcolor;
			`GS_REG_NEWVIDEO:  rdata = newvideo;
			`GS_REG_C02B:      rdata = c02b;
			`GS_REG_SLTROMSEL: rdata = sltromsel;
			`GS_REG_BORDER:    rdata = {4'h0, bordercolor};
			`GS_REG_SHADOW:    rdata = shadow;
			`GS_REG_CYA:       rdata = cya;
			12'h02a, 12'h02c, 12'h037: rdata = 8'h00; // unused, read as zero
			`GS_REG_STATE:
				rdata = {altzp, page2, ramrd, ramwrt, !rdrom, lcram2, rombank, intcxrom};
			default: hit = 1'b0;
		endcase
	end

endmodule

// File: hdl/gs_pkg.sv
package gs_pkg;

	// what an access in the internal I/O window does
	typedef enum logic [1:0] {
		BUS_IDLE  = 2'd0,
		BUS_READ  = 2'd1,
		BUS_WRITE = 2'd2
	} bus_op_e;

	// language card modes, indexed by {addr[3], addr[1], addr[0]}
	// so C084-C087 and C08C-C08F echo the four modes below them
	typedef enum logic [2:0] {
		LC_RAM_B2_RO = 3'd0, // C080
		LC_ROM_B2_WE = 3'd1, // C081
		LC_ROM_B2_RO = 3'd2, // C082
		LC_RAM_B2_WE = 3'd3, // C083
		LC_RAM_B1_RO = 3'd4, // C088
		LC_ROM_B1_WE = 3'd5, // C089
		LC_ROM_B1_RO = 3'd6, // C08A
		LC_RAM_B1_WE = 3'd7  // C08B
	} lc_mode_e;

	// banks that see the I/O page and the language card
	function automatic logic is_io_bank(input logic [7:0] bank);
		logic hit;
		hit = (bank == 8'h00) || (bank == 8'h01) || (bank == 8'he0) || (bank == 8'he1);
		return hit;
	endfunction

endpackage

// File: hdl/gs_read_mux.sv
`timescale 1ns/1ps

module gs_read_mux (
	input  logic            clk_sys,
	input  logic            cpu_vda,
	input  gs_pkg::bus_op_e io_op,
	input  logic [7:0]      sw_rdata,
	input  logic            sw_hit,
	input  logic [7:0]      reg_rdata,
	input  logic            reg_hit,
	input  logic [7:0]      din,
	output logic [7:0]      cpu_din
);

	logic [7:0] io_rdata;
	logic       hold;

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda)
			hold <= 1'b0;
		else
			hold <= (io_op == gs_pkg::BUS_READ);
	end

	// unclaimed I/O offsets read as zero
	always_ff @(posedge clk_sys) begin
		if (io_op == gs_pkg::BUS_READ)
			io_rdata <= sw_hit ? sw_rdata : (reg_hit ? reg_rdata : 8'h00);
	end

	assign cpu_din = hold ? io_rdata : din;

	one_owner_a: assert property (@(posedge clk_sys) disable iff (cpu_vda)
		!(sw_hit && reg_hit));

endmodule

// File: hdl/gs_softswitch.sv
`timescale 1ns/1ps
`include "gs_macros.svh"

module gs_softswitch (
	input  logic            clk_sys,
	input  logic            cpu_vda,
	input  logic [15:0]     addr,
	input  gs_pkg::bus_op_e io_op,
	input  logic [7:0]      cpu_wdata,
	input  logic            vblank,
	input  logic            lcram2,
	input  logic            rdrom,
	input  logic            state_load,
	input  logic [7:0]      state_wdata,
	output logic            store80,
	output logic            ramrd,
	output logic            ramwrt,
	output logic            intcxrom,
	output logic            altzp,
	output logic            page2,
	output logic            textg,
	output logic            mixg,
	output logic            hires_mode,
	output logic [7:0]      rdata,
	output logic            hit
);

	logic slotc3rom;
	logic eightycol;
	logic altcharset;
	logic rd;
	logic wr;
	logic mem_sw;
	logic vid_sw;
	logic status;

	assign rd = (io_op == gs_pkg::BUS_READ);
	assign wr = (io_op == gs_pkg::BUS_WRITE);

	// C000-C00F on writes; RAMRD/RAMWRT (C002-C005) also on reads
	assign mem_sw = (addr[11:4] == 8'h00) &&
		(wr || (rd && (addr[3:1] == 3'd1 || addr[3:1] == 3'd2)));
	assign vid_sw = (io_op != gs_pkg::BUS_IDLE) && (addr[11:3] == 9'h00a); // C050-C057

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			store80    <= 1'b0;
			ramrd      <= 1'b0;
			ramwrt     <= 1'b0;
			intcxrom   <= 1'b1;
			altzp      <= 1'b0;
			slotc3rom  <= 1'b0;
			eightycol  <= 1'b0;
			altcharset <= 1'b0;
			page2      <= 1'b0;
			textg      <= 1'b0;
			mixg       <= 1'b0;
			hires_mode <= 1'b0;
		end else if (state_load) begin
			altzp    <= state_wdata[7];
			page2    <= state_wdata[6];
			ramrd    <= state_wdata[5];
			ramwrt   <= state_wdata[4];
			intcxrom <= state_wdata[0];
		end else begin
			// even offset clears, odd sets; data byte is ignored
			if (mem_sw) begin
				case (addr[3:1])
					3'd0: store80    <= addr[0];
					3'd1: ramrd      <= addr[0];
					3'd2: ramwrt     <= addr[0];
					3'd3: intcxrom   <= addr[0];
					3'd4: altzp      <= addr[0];
					3'd5: slotc3rom  <= addr[0];
					3'd6: eightycol  <= addr[0];
					default: altcharset <= addr[0];
				endcase
			end
			if (vid_sw) begin
				case (addr[2:1])
					2'd0: textg      <= addr[0];
					2'd1: mixg       <= addr[0];
					2'd2: page2      <= addr[0];
					default: hires_mode <= addr[0];
				endcase
			end
		end
	end

	// status reads, C010 is the keyboard strobe and not ours
	always_comb begin
		case (addr[3:0])
			4'h1: status = lcram2;
			4'h2: status = rdrom;
			4'h3: status = ramrd;
			4'h4: status = ramwrt;
			4'h5: status = intcxrom;
			4'h6: status = altzp;
			4'h7: status = slotc3rom;
			4'h8: status = store80;
			4'h9: status = !vblank; // high outside blanking
			4'ha: status = textg;
			4'hb: status = mixg;
			4'hc: status = page2;
			4'hd: status = !hires_mode;
			4'he: status = altcharset;
			4'hf: status = eightycol;
			default: status = 1'b0;
		endcase
	end

	assign hit   = rd && (addr[11:4] == 8'h01) && (addr[3:0] != 4'h0);
	assign rdata = status ? `GS_STATUS_ON : 8'h00;

endmodule

// File: sim/tb_gs_table.svh
`ifndef TB_GS_TABLE_SVH
`define TB_GS_TABLE_SVH

// name, bank, addr, write, data, vblank, output checked, expected, flags
// data is driven on cpu_wdata and din alike

// values after reset
add_row("rst_shadow",   8'h02, 16'h0000, 0, 8'h00, 0, OUT_SHADOW,   16'h0008, 0);
add_row("rst_newvideo", 8'h02, 16'h0000, 0, 8'h00, 0, OUT_NEWVIDEO, 16'h0041, 0);
add_row("rst_lc",       8'h02, 16'h0000, 0, 8'h00, 0, OUT_LC,       16'h0006, 0);
add_row("rst_cxrom",    8'h02, 16'h0000, 0, 8'h00, 0, OUT_CXROM,    16'h0001, 0);

// soft switches and status reads
add_row("w_c001",       8'h00, 16'hc001, 1, 8'h00, 0, OUT_NONE,     16'h0000, 0);
add_row("w_c055",       8'h00, 16'hc055, 1, 8'h00, 0, OUT_NONE,     16'h0000, 0);
add_row("r_c018",       8'h00, 16'hc018, 0, 8'h00, 0, OUT_DIN,      16'h0080, 0);
add_row("r_c01c",       8'h00, 16'hc01c, 0, 8'h00, 0, OUT_DIN,      16'h0080, 0);
add_row("r_c019_vbl0",  8'h00, 16'hc019, 0, 8'h00, 0, OUT_DIN,      16'h0080, 0);
add_row("r_c019_vbl1",  8'h00, 16'hc019, 0, 8'h00, 1, OUT_DIN,      16'h0000, 0);

// video switches, {page2, textg, mixg, hires_mode}
add_row("w_c051",       8'h00, 16'hc051, 1, 8'h00, 0, OUT_VIDEO,    16'h000c, 0);
add_row("w_c053",       8'h00, 16'hc053, 1, 8'h00, 0, OUT_VIDEO,    16'h000e, 0);
add_row("w_c057",       8'h00, 16'hc057, 1, 8'h00, 0, OUT_VIDEO,    16'h000f, 0);
add_row("w_c056",       8'h00, 16'hc056, 1, 8'h00, 0, OUT_VIDEO,    16'h000e, 0);

// language card modes, {rdrom, lcram2, lc_we}
add_row("lc_c080",      8'h00, 16'hc080, 0, 8'h00, 0, OUT_LC,       16'h0002, 0);
add_row("lc_c081",      8'h00, 16'hc081, 0, 8'h00, 0, OUT_LC,       16'h0007, 0);
add_row("lc_c082",      8'h00, 16'hc082, 1, 8'h00, 0, OUT_LC,       16'h0006, 0);
add_row("lc_c083",      8'h00, 16'hc083, 0, 8'h00, 0, OUT_LC,       16'h0003, 0);
add_row("lc_c084",      8'h00, 16'hc084, 0, 8'h00, 0, OUT_LC,       16'h0002, 0);
add_row("lc_c085",      8'h00, 16'hc085, 1, 8'h00, 0, OUT_LC,       16'h0007, 0);
add_row("lc_c086",      8'h00, 16'hc086, 0, 8'h00, 0, OUT_LC,       16'h0006, 0);
add_row("lc_c087",      8'h00, 16'hc087, 0, 8'h00, 0, OUT_LC,       16'h0003, 0);
add_row("lc_c088",      8'h00, 16'hc088, 1, 8'h00, 0, OUT_LC,       16'h0000, 0);
add_row("lc_c089",      8'h00, 16'hc089, 0, 8'h00, 0, OUT_LC,       16'h0005, 0);
add_row("lc_c08a",      8'h00, 16'hc08a, 0, 8'h00, 0, OUT_LC,       16'h0004, 0);
add_row("lc_c08b",      8'h00, 16'hc08b, 1, 8'h00, 0, OUT_LC,       16'h0001, 0);
add_row("lc_c08c",      8'h00, 16'hc08c, 0, 8'h00, 0, OUT_LC,       16'h0000, 0);
add_row("lc_c08d",      8'h00, 16'hc08d, 0, 8'h00, 0, OUT_LC,       16'h0005, 0);
add_row("lc_c08e",      8'h00, 16'hc08e, 1, 8'h00, 0, OUT_LC,       16'h0004, 0);
add_row("lc_c08f",      8'h00, 16'hc08f, 0, 8'h00, 0, OUT_LC,       16'h0001, 0);
add_row("lc_c080_b2",   8'h00, 16'hc080, 0, 8'h00, 0, OUT_LC,       16'h0002, 0);

// bank 2 RAM read moves D000 down only in the I/O banks
add_row("remap_b00",    8'h00, 16'hd123, 0, 8'h00, 0, OUT_ADDR,     16'hc123, 0);
add_row("remap_b02",    8'h02, 16'hd123, 0, 8'h00, 0, OUT_ADDR,     16'hd123, 0);
add_row("bank_be1",     8'he1, 16'hd123, 0, 8'h00, 0, OUT_BANK,     16'h00e1, 0);

// register readback with lfsr data
add_row("w_c029",       8'h00, 16'hc029, 1, 8'h00, 0, OUT_NONE,     16'h0000, F_RAND);
add_row("r_c029",       8'h00, 16'hc029, 0, 8'h00, 0, OUT_DIN,      16'h0000, F_LAST);
add_row("w_c022",       8'h00, 16'hc022, 1, 8'h00, 0, OUT_TEXTCOLOR, 16'h0000, F_RAND | F_LAST);
add_row("r_c022",       8'h00, 16'hc022, 0, 8'h00, 0, OUT_DIN,      16'h0000, F_LAST);
add_row("w_c02d",       8'h00, 16'hc02d, 1, 8'h00, 0, OUT_SLTROMSEL, 16'h0000, F_RAND | F_LAST);
add_row("r_c02d",       8'h00, 16'hc02d, 0, 8'h00, 0, OUT_DIN,      16'h0000, F_LAST);
add_row("w_c036",       8'h00, 16'hc036, 1, 8'h00, 0, OUT_NONE,     16'h0000, F_RAND);
add_row("r_c036",       8'h00, 16'hc036, 0, 8'h00, 0, OUT_DIN,      16'h0000, F_LAST);
add_row("w_c034",       8'h00, 16'hc034, 1, 8'hb7, 0, OUT_BORDER,   16'h0007, 0);
add_row("w_c068",       8'h00, 16'hc068, 1, 8'h0d, 0, OUT_RDROM,    16'h0000, 0);
add_row("r_c068",       8'h00, 16'hc068, 0, 8'h00, 0, OUT_DIN,      16'h000d, 0);

// widened window and slot carve-out
add_row("lc_rom",       8'h00, 16'hc082, 0, 8'h00, 0, OUT_LC,       16'h0006, 0);
add_row("w_shadow",     8'h00, 16'hc035, 1, 8'h48, 0, OUT_SHADOW,   16'h0048, 0);
add_row("io_d000",      8'h00, 16'hd000, 0, 8'h00, 0, OUT_IO,       16'h0001, 0);
add_row("w_sltromsel",  8'h00, 16'hc02d, 1, 8'h06, 0, OUT_NONE,     16'h0000, 0);
add_row("io_c0a0",      8'h00, 16'hc0a0, 0, 8'h00, 0, OUT_IO,       16'h0000, 0);
add_row("din_c0a0",     8'h00, 16'hc0a0, 0, 8'h5a, 0, OUT_DIN,      16'h005a, 0);

// aux bank select
add_row("w_c005",       8'h00, 16'hc005, 1, 8'h00, 0, OUT_NONE,     16'h0000, 0);
add_row("aux_b00",      8'h00, 16'h0800, 1, 8'h00, 0, OUT_AUX,      16'h0001, 0);
add_row("aux_b01",      8'h01, 16'h0800, 1, 8'h00, 0, OUT_AUX,      16'h0000, 0);
add_row("w_c004",       8'h00, 16'hc004, 1, 8'h00, 0, OUT_NONE,     16'h0000, 0);
add_row("aux_b00_main", 8'h00, 16'h0800, 1, 8'h00, 0, OUT_AUX,      16'h0000, 0);
add_row("w_c055_again", 8'h00, 16'hc055, 1, 8'h00, 0, OUT_NONE,     16'h0000, 0);
add_row("aux_0400_p2",  8'h00, 16'h0400, 0, 8'h00, 0, OUT_AUX,      16'h0001, 0);
add_row("w_c054",       8'h00, 16'hc054, 1, 8'h00, 0, OUT_NONE,     16'h0000, 0);
add_row("aux_0400_p1",  8'h00, 16'h0400, 0, 8'h00, 0, OUT_AUX,      16'h0000, 0);

`endif

// File: sim/tb_gs_glue.sv
`timescale 1ns/1ps

module tb_gs_glue;

	localparam int CLK_PERIOD = 8;
	localparam int MAX_ROWS   = 80;

	// which DUT output a table row checks
	localparam int OUT_NONE      = 0;
	localparam int OUT_DIN       = 1;  // cpu_din in the cycle after the access
	localparam int OUT_BANK      = 2;
	localparam int OUT_IO        = 3;
	localparam int OUT_ADDR      = 4;
	localparam int OUT_AUX       = 5;
	localparam int OUT_SHADOW    = 6;
	localparam int OUT_NEWVIDEO  = 7;
	localparam int OUT_CXROM     = 8;
	localparam int OUT_RDROM     = 9;
	localparam int OUT_LC        = 10; // {rdrom, lcram2, lc_we}
	localparam int OUT_BORDER    = 11;
	localparam int OUT_TEXTCOLOR = 12;
	localparam int OUT_SLTROMSEL = 13;
	localparam int OUT_VIDEO     = 14; // {page2, textg, mixg, hires_mode}

	localparam int F_RAND = 1; // data byte drawn from the lfsr
	localparam int F_LAST = 2; // expected is the last drawn byte

	logic        clk_sys = 1'b0;
	logic        cpu_vda;
	logic        bus_valid;
	logic        bus_write;
	logic [7:0]  cpu_bank;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata;
	logic [7:0]  din;
	logic        vblank;
	logic [7:0]  bank;
	logic [15:0] addr;
	logic [7:0]  cpu_din;
	logic        io;
	logic        aux;
	logic [7:0]  shadow;
	logic [7:0]  newvideo;
	logic [7:0]  textcolor;
	logic [3:0]  bordercolor;
	logic [7:0]  sltromsel;
	logic        cxrom;
	logic        rdrom;
	logic        lcram2;
	logic        lc_we;
	logic        page2;
	logic        textg;
	logic        mixg;
	logic        hires_mode;

	string       row_name  [MAX_ROWS];
	logic [7:0]  row_bank  [MAX_ROWS];
	logic [15:0] row_addr  [MAX_ROWS];
	logic        row_wr    [MAX_ROWS];
	logic [7:0]  row_data  [MAX_ROWS];
	logic        row_vbl   [MAX_ROWS];
	int          row_out   [MAX_ROWS];
	logic [15:0] row_exp   [MAX_ROWS];
	int          row_flags [MAX_ROWS];
	int          num_rows = 0;

	logic [31:0] lfsr = 32'h3d1d;
	logic [7:0]  last_drawn = 8'h00;
	int          errors = 0;
	int          cycles = 0;
	int          timeout_cycles = 1000;

	gs_glue gs_glue_i (
		.clk_sys     (clk_sys),
		.cpu_vda     (cpu_vda),
		.bus_valid   (bus_valid),
		.bus_write   (bus_write),
		.cpu_bank    (cpu_bank),
		.cpu_addr    (cpu_addr),
		.cpu_wdata   (cpu_wdata),
		.din         (din),
		.vblank      (vblank),
		.bank        (bank),
		.addr        (addr),
		.cpu_din     (cpu_din),
		.io          (io),
		.aux         (aux),
		.shadow      (shadow),
		.newvideo    (newvideo),
		.textcolor   (textcolor),
		.bordercolor (bordercolor),
		.sltromsel   (sltromsel),
		.cxrom       (cxrom),
		.rdrom       (rdrom),
		.lcram2      (lcram2),
		.lc_we       (lc_we),
		.page2       (page2),
		.textg       (textg),
		.mixg        (mixg),
		.hires_mode  (hires_mode)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	task automatic add_row(input string name, input logic [7:0] bnk, input logic [15:0] adr,
			input logic wr, input logic [7:0] data, input logic vbl, input int out,
			input logic [15:0] expected, input int flags);
		row_name[num_rows]  = name;
		row_bank[num_rows]  = bnk;
		row_addr[num_rows]  = adr;
		row_wr[num_rows]    = wr;
		row_data[num_rows]  = data;
		row_vbl[num_rows]   = vbl;
		row_out[num_rows]   = out;
		row_exp[num_rows]   = expected;
		row_flags[num_rows] = flags;
		num_rows++;
	endtask

	task automatic build_table;
`include "tb_gs_table.svh"
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_byte(output logic [7:0] b);
		int k;
		b = 8'h00;
		for (k = 0; k < 8; k++) begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[0]}; // one step per bit
		end
	endtask

	function automatic logic [15:0] pick_output(input int sel);
		case (sel)
			OUT_DIN:       return {8'h00, cpu_din};
			OUT_BANK:      return {8'h00, bank};
			OUT_IO:        return {15'd0, io};
			OUT_ADDR:      return addr;
			OUT_AUX:       return {15'd0, aux};
			OUT_SHADOW:    return {8'h00, shadow};
			OUT_NEWVIDEO:  return {8'h00, newvideo};
			OUT_CXROM:     return {15'd0, cxrom};
			OUT_RDROM:     return {15'd0, rdrom};
			OUT_LC:        return {13'd0, rdrom, lcram2, lc_we};
			OUT_BORDER:    return {12'd0, bordercolor};
			OUT_TEXTCOLOR: return {8'h00, textcolor};
			OUT_SLTROMSEL: return {8'h00, sltromsel};
			OUT_VIDEO:     return {12'd0, page2, textg, mixg, hires_mode};
			default:       return 16'h0000;
		endcase
	endfunction

	task automatic compare(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// one access cycle, then one idle cycle
	task automatic run_row(input int idx);
		logic [7:0]  data;
		logic [15:0] expected;
		logic [15:0] during;
		logic [15:0] after;
		data = row_data[idx];
		if (row_flags[idx] & F_RAND) begin
			draw_byte(data);
			last_drawn = data;
		end
		expected = (row_flags[idx] & F_LAST) ? {8'h00, last_drawn} : row_exp[idx];

		@(negedge clk_sys);
		bus_valid = 1'b1;
		bus_write = row_wr[idx];
		cpu_bank  = row_bank[idx];
		cpu_addr  = row_addr[idx];
		cpu_wdata = data;
		din       = data;
		vblank    = row_vbl[idx];
		#(CLK_PERIOD / 4) during = pick_output(row_out[idx]);

		@(negedge clk_sys);
		bus_valid = 1'b0;
		#(CLK_PERIOD / 4) after = pick_output(row_out[idx]);

		case (row_out[idx])
			OUT_NONE: ;
			OUT_IO, OUT_ADDR, OUT_AUX, OUT_BANK: compare(row_name[idx], expected, during);
			default: compare(row_name[idx], expected, after);
		endcase
	endtask

	initial begin
		int i;
		cpu_vda   = 1'b1;
		bus_valid = 1'b0;
		bus_write = 1'b0;
		cpu_bank  = 8'h00;
		cpu_addr  = 16'h0000;
		cpu_wdata = 8'h00;
		din       = 8'h00;
		vblank    = 1'b0;

		build_table();
		timeout_cycles = num_rows * 4 + 50;

		repeat (4) @(negedge clk_sys);
		cpu_vda = 1'b0;

		for (i = 0; i < num_rows; i++)
			run_row(i);

		$display("%0d error(s) over %0d rows", errors, num_rows);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > timeout_cycles) begin
			$display("timeout, the run hung after %0d cycles", cycles);
			$display("%0d error(s) before the timeout", errors);
			$display("Test failed");
			$finish;
		end
	end

endmodule

// File: tb.f
+incdir+hdl
+incdir+sim
hdl/gs_pkg.sv
hdl/gs_io_decode.sv
hdl/gs_lang_card.sv
hdl/gs_softswitch.sv
hdl/gs_megaii_regs.sv
hdl/gs_aux_select.sv
hdl/gs_read_mux.sv
hdl/gs_glue.sv
sim/tb_gs_glue.sv
